/* r4_last_stage.f */
+incdir+testbench
rtl/r4_stage_pkg.sv
rtl/r4_group_collector.sv
rtl/r4_butterfly.sv
rtl/digit_reverse_buffer.sv
rtl/r4_last_stage.sv
testbench/tb_r4_last_stage.sv

/* rtl/digit_reverse_buffer.sv */
`timescale 1ns/100ps

module digit_reverse_buffer #(
  parameter int N_POINTS = 64
) (
  input  logic                clk,
  input  logic                rst,
  input  r4_stage_pkg::cplx_t result_i,
  input  logic [1:0]          result_idx_i,
  input  logic                result_valid_i,
  output r4_stage_pkg::cplx_t data_o,
  output logic                data_valid_o
);

  localparam int ADDR_W = $clog2(N_POINTS);
  localparam int GRP_W  = ADDR_W - 2;  // groups per frame, N_POINTS of at least 16

  logic [GRP_W-1:0]       grp_cnt_q;
  logic [ADDR_W-1:0]      wr_addr;
  logic                   wr_bank_q;
  logic                   swap;
  logic [ADDR_W-1:0]      rd_cnt_q;
  r4_stage_pkg::rd_state_e rd_state_q;

  r4_stage_pkg::cplx_t mem_q [2*N_POINTS];  // bank select is the top address bit

  // base-4 digit reversal, lowest digit of pos becomes the highest
  function automatic logic [ADDR_W-1:0] digit_rev(input logic [ADDR_W-1:0] pos);
    logic [ADDR_W-1:0] rev;
    rev = '0;
    for (int d = 0; d < ADDR_W / 2; d++) begin
      rev[2*d +: 2] = pos[ADDR_W-2-2*d +: 2];
    end
    return rev;
  endfunction

  assign wr_addr = digit_rev({grp_cnt_q, result_idx_i});
  assign swap    = result_valid_i && (result_idx_i == 2'd3) && (&grp_cnt_q);

  always_ff @(posedge clk) begin
    if (result_valid_i) begin
      mem_q[{wr_bank_q, wr_addr}] <= result_i;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      grp_cnt_q <= '0;
      wr_bank_q <= 1'b0;
    end else begin
      if (result_valid_i && result_idx_i == 2'd3) begin
        grp_cnt_q <= grp_cnt_q + 1'b1;  // wraps at end of frame
      end
      if (swap) begin
        wr_bank_q <= ~wr_bank_q;
      end
    end
  end

  // read side streams the bank that was just completed
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rd_state_q <= r4_stage_pkg::RD_IDLE;
      rd_cnt_q   <= '0;
    end else begin
      case (rd_state_q)
        r4_stage_pkg::RD_IDLE: begin
          if (swap) begin
            rd_state_q <= r4_stage_pkg::RD_STREAM;
            rd_cnt_q   <= '0;
          end
        end
        default: begin
          rd_cnt_q <= rd_cnt_q + 1'b1;
          if (&rd_cnt_q && !swap) begin
            rd_state_q <= r4_stage_pkg::RD_IDLE;  // back to back frames stay here
          end
        end
      endcase
    end
  end

  assign data_o       = mem_q[{~wr_bank_q, rd_cnt_q}];
  assign data_valid_o = (rd_state_q == r4_stage_pkg::RD_STREAM);

  // a burst must be done before the next frame completes
  a_no_early_swap: assert property (@(posedge clk) disable iff (!rst)
    swap |-> (rd_state_q == r4_stage_pkg::RD_IDLE) || (&rd_cnt_q));

endmodule

/* rtl/r4_butterfly.sv */
`timescale 1ns/100ps

module r4_butterfly #(
  parameter int SCALE_SHIFT = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  input  r4_stage_pkg::group_t group_i,
  input  logic                 group_valid_i,
  output r4_stage_pkg::cplx_t  result_o,
  output logic [1:0]           result_idx_o,
  output logic                 result_valid_o
);

  localparam int ACC_W    = r4_stage_pkg::ACC_W;
  localparam int SAMPLE_W = r4_stage_pkg::SAMPLE_W;

  logic signed [ACC_W-1:0] xr [4];  // sign extended inputs
  logic signed [ACC_W-1:0] xi [4];
  logic signed [ACC_W-1:0] yr [4];  // full width butterfly sums
  logic signed [ACC_W-1:0] yi [4];

  r4_stage_pkg::cplx_t res_q [4];
  logic [1:0]          phase_q;
  logic                busy_q;

  function automatic logic signed [SAMPLE_W-1:0] scale(input logic signed [ACC_W-1:0] v);
    logic signed [ACC_W-1:0] s;
    s = v >>> SCALE_SHIFT;
    return s[SAMPLE_W-1:0];  // plain truncation
  endfunction

  assign xr[0] = ACC_W'(group_i.x0.re);
  assign xi[0] = ACC_W'(group_i.x0.im);
  assign xr[1] = ACC_W'(group_i.x1.re);
  assign xi[1] = ACC_W'(group_i.x1.im);
  assign xr[2] = ACC_W'(group_i.x2.re);
  assign xi[2] = ACC_W'(group_i.x2.im);
  assign xr[3] = ACC_W'(group_i.x3.re);
  assign xi[3] = ACC_W'(group_i.x3.im);

  // -j rotation swaps parts and negates the new imaginary part
  assign yr[0] = xr[0] + xr[1] + xr[2] + xr[3];
  assign yi[0] = xi[0] + xi[1] + xi[2] + xi[3];
  assign yr[1] = xr[0] + xi[1] - xr[2] - xi[3];
  assign yi[1] = xi[0] - xr[1] - xi[2] + xr[3];
  assign yr[2] = xr[0] - xr[1] + xr[2] - xr[3];
  assign yi[2] = xi[0] - xi[1] + xi[2] - xi[3];
  assign yr[3] = xr[0] - xi[1] - xr[2] + xi[3];
  assign yi[3] = xi[0] + xr[1] - xi[2] - xr[3];

  always_ff @(posedge clk) begin
    if (group_valid_i) begin
      for (int k = 0; k < 4; k++) begin
        res_q[k].re <= scale(yr[k]);
        res_q[k].im <= scale(yi[k]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      busy_q  <= 1'b0;
      phase_q <= 2'd0;
    end else if (group_valid_i) begin
      busy_q  <= 1'b1;
      phase_q <= 2'd0;
    end else if (busy_q) begin
      phase_q <= phase_q + 2'd1;
      if (phase_q == 2'd3) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign result_o       = res_q[phase_q];
  assign result_idx_o   = phase_q;
  assign result_valid_o = busy_q;

  // collector spaces groups so the four issues of one never meet the next
  a_no_overlap: assert property (@(posedge clk) disable iff (!rst)
    group_valid_i |=> !group_valid_i [*3]);

endmodule

/* rtl/r4_group_collector.sv */
`timescale 1ns/100ps

module r4_group_collector (
  input  logic                 clk,
  input  logic                 rst,
  input  r4_stage_pkg::cplx_t  sample_i,
  input  logic                 sample_valid_i,
  output r4_stage_pkg::group_t group_o,
  output logic                 group_valid_o
);

  logic [1:0]          slot_q;  // position of the next sample in its group
  r4_stage_pkg::cplx_t s0_q;
  r4_stage_pkg::cplx_t s1_q;
  r4_stage_pkg::cplx_t s2_q;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      slot_q        <= 2'd0;
      group_valid_o <= 1'b0;
    end else begin
      group_valid_o <= sample_valid_i && (slot_q == 2'd3);
      if (sample_valid_i) begin
        slot_q <= slot_q + 2'd1;  // wraps after the fourth sample
      end
    end
  end

  // sample holding and group assembly
  always_ff @(posedge clk) begin
    if (sample_valid_i) begin
      case (slot_q)
        2'd0: begin
          s0_q <= sample_i;
        end
        2'd1: begin
          s1_q <= sample_i;
        end
        2'd2: begin
          s2_q <= sample_i;
        end
        default: begin
          group_o.x0 <= s0_q;
          group_o.x1 <= s1_q;
          group_o.x2 <= s2_q;
          group_o.x3 <= sample_i;  // fourth one goes straight in
        end
      endcase
    end
  end

endmodule

/* rtl/r4_last_stage.sv */
`timescale 1ns/100ps

module r4_last_stage #(
  parameter int N_POINTS    = 64,
  parameter int SCALE_SHIFT = 2
) (
  input  logic                clk,
  input  logic                rst,
  input  r4_stage_pkg::cplx_t sample_i,
  input  logic                sample_valid_i,
  output r4_stage_pkg::cplx_t data_o,
  output logic                data_valid_o
);

  r4_stage_pkg::group_t group;
  logic                 group_valid;
  r4_stage_pkg::cplx_t  result;
  logic [1:0]           result_idx;  // k of the butterfly output
  logic                 result_valid;

  r4_group_collector i_r4_group_collector (
    .clk            (clk),
    .rst            (rst),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .group_o        (group),
    .group_valid_o  (group_valid)
  );

  r4_butterfly #(
    .SCALE_SHIFT (SCALE_SHIFT)
  ) i_r4_butterfly (
    .clk            (clk),
    .rst            (rst),
    .group_i        (group),
    .group_valid_i  (group_valid),
    .result_o       (result),
    .result_idx_o   (result_idx),
    .result_valid_o (result_valid)
  );

  digit_reverse_buffer #(
    .N_POINTS (N_POINTS)
  ) i_digit_reverse_buffer (
    .clk            (clk),
    .rst            (rst),
    .result_i       (result),
    .result_idx_i   (result_idx),
    .result_valid_i (result_valid),
    .data_o         (data_o),
    .data_valid_o   (data_valid_o)
  );

endmodule

/* rtl/r4_stage_pkg.sv */
package r4_stage_pkg;

  // width of one real or imaginary part
  localparam int SAMPLE_W = 16;

  // four-term butterfly sum needs two guard bits
  localparam int ACC_W = SAMPLE_W + 2;

  typedef struct packed {
    logic signed [SAMPLE_W-1:0] re;
    logic signed [SAMPLE_W-1:0] im;
  } cplx_t;

  // x0 is the first sample of the group in arrival order
  typedef struct packed {
    cplx_t x0;
    cplx_t x1;
    cplx_t x2;
    cplx_t x3;
  } group_t;

  typedef enum logic {
    RD_IDLE   = 1'b0,  // waiting for a full bank
    RD_STREAM = 1'b1   // bank being read in natural order
  } rd_state_e;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the r4_last_stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f r4_last_stage.f \
  --top-module tb_r4_last_stage \
  -o sim_r4_last_stage

./obj_dir/sim_r4_last_stage | tee sim.log

if grep -q "TB PASSED" sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi

/* testbench/tb_r4_model.svh */
`ifndef TB_R4_MODEL_SVH
`define TB_R4_MODEL_SVH

// base-4 digit reversal of a frame position
function automatic int rev_digits(input int pos);
  int rev;
  int p;
  rev = 0;
  p = pos;
  for (int span = 1; span < N_POINTS; span = span * 4) begin
    rev = rev * 4 + (p % 4);
    p = p / 4;
  end
  return rev;
endfunction

// multiply re + j*im by (-j)^p
function automatic void rotate(input int re, input int im, input int p,
                               output int out_re, output int out_im);
  case (p % 4)
    0: begin
      out_re = re;
      out_im = im;
    end
    1: begin
      out_re = im;  // times -j
      out_im = -re;
    end
    2: begin
      out_re = -re;
      out_im = -im;
    end
    default: begin
      out_re = -im;  // times +j
      out_im = re;
    end
  endcase
endfunction

// natural order output frame for one input frame
function automatic void expected_frame(input r4_stage_pkg::cplx_t frame_in [N_POINTS],
                                       output r4_stage_pkg::cplx_t frame_out [N_POINTS]);
  int acc_re;
  int acc_im;
  int rot_re;
  int rot_im;
  logic [31:0] shifted_re;
  logic [31:0] shifted_im;
  for (int g = 0; g < N_POINTS / 4; g++) begin
    for (int k = 0; k < 4; k++) begin
      acc_re = 0;
      acc_im = 0;
      for (int m = 0; m < 4; m++) begin
        rotate(int'(frame_in[4*g+m].re), int'(frame_in[4*g+m].im), m * k, rot_re, rot_im);
        acc_re = acc_re + rot_re;
        acc_im = acc_im + rot_im;
      end
      shifted_re = acc_re >>> SCALE_SHIFT;
      shifted_im = acc_im >>> SCALE_SHIFT;
      frame_out[rev_digits(4*g+k)].re = shifted_re[SAMPLE_W-1:0];
      frame_out[rev_digits(4*g+k)].im = shifted_im[SAMPLE_W-1:0];
    end
  end
endfunction

`endif

/* testbench/tb_r4_last_stage.sv */
`timescale 1ns/100ps

module tb_r4_last_stage;

  localparam int N_POINTS       = 64;
  localparam int SCALE_SHIFT    = 2;
  localparam int SAMPLE_W       = r4_stage_pkg::SAMPLE_W;
  localparam int NUM_FRAMES     = 5;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * N_POINTS * 3 + 100;
  localparam int IMPULSE_AMP    = 4096;  // unit impulse scaled up past the shift
  localparam int LATENCY        = 6;

  logic                clk;
  logic                rst;
  r4_stage_pkg::cplx_t sample_i;
  logic                sample_valid_i;
  r4_stage_pkg::cplx_t data_o;
  logic                data_valid_o;

  integer              seed;
  int                  cycle_cnt = 0;
  int                  out_idx = 0;
  int                  frames_seen = 0;
  r4_stage_pkg::cplx_t exp_q [$];
  int                  last_strobe_q [$];  // edge that sampled each frame's last strobe
  r4_stage_pkg::cplx_t gapped_out [N_POINTS];
  r4_stage_pkg::cplx_t impulse_out;

  `include "tb_r4_model.svh"

  r4_last_stage #(
    .N_POINTS    (N_POINTS),
    .SCALE_SHIFT (SCALE_SHIFT)
  ) i_r4_last_stage (
    .clk            (clk),
    .rst            (rst),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .data_o         (data_o),
    .data_valid_o   (data_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED time=%0t signal=%s expected=0x%08h actual=0x%08h",
               $time, name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "stopping on mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s at time %0t", reason, $time);
    $display("TB FAILED");
    $fatal(1, "stopping on error");
  endtask

  task automatic wait_drive_slot();
    @(posedge clk);
    #2;
  endtask

  task automatic fill_random(output r4_stage_pkg::cplx_t frame [N_POINTS]);
    int r;
    for (int i = 0; i < N_POINTS; i++) begin
      r = $random(seed) % 8192;  // stays within +-2^13
      frame[i].re = SAMPLE_W'(r);
      r = $random(seed) % 8192;
      frame[i].im = SAMPLE_W'(r);
    end
  endtask

  task automatic send_idle(input int cycles);
    repeat (cycles) begin
      wait_drive_slot();
      sample_valid_i = 1'b0;
    end
  endtask

  // leaves the strobe high so the next frame can follow without a gap
  task automatic send_frame(input r4_stage_pkg::cplx_t frame [N_POINTS], input bit gapped);
    r4_stage_pkg::cplx_t exp_frame [N_POINTS];
    int gap;
    expected_frame(frame, exp_frame);
    for (int i = 0; i < N_POINTS; i++) begin
      if (gapped && i > 0) begin
        gap = 1 + int'({$random(seed)} % 3);
        send_idle(gap);
      end
      wait_drive_slot();
      sample_i       = frame[i];
      sample_valid_i = 1'b1;
    end
    for (int i = 0; i < N_POINTS; i++) begin
      exp_q.push_back(exp_frame[i]);
    end
    last_strobe_q.push_back(cycle_cnt + 1);
  endtask

  always @(posedge clk) begin : timeout_watch
    r4_stage_pkg::rd_state_e rd_state;
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      rd_state = i_r4_last_stage.i_digit_reverse_buffer.rd_state_q;
      $display("run timed out after %0d cycles with %0d of %0d frames seen, read state %s",
               cycle_cnt, frames_seen, NUM_FRAMES, rd_state.name());
      $display("TB FAILED");
      $fatal(1, "stopping on timeout");
    end
  end

  // outputs are sampled mid cycle where they are stable
  always @(negedge clk) begin : compare_outputs
    r4_stage_pkg::cplx_t want;
    int strobe_edge;
    if (rst) begin
      if (data_valid_o) begin
        if (exp_q.size() == 0) begin
          abort_run("data_valid_o went high while no completed frame was pending");
        end
        if (out_idx == 0) begin
          strobe_edge = last_strobe_q.pop_front();
          check_value("first output latency", LATENCY, cycle_cnt + 1 - strobe_edge);
        end
        want = exp_q.pop_front();
        if (frames_seen == 1) begin
          gapped_out[out_idx] = data_o;  // gapped frame is held against its ungapped copy
        end else begin
          check_value("data_o", want, data_o);
        end
        if (frames_seen == 0 && (out_idx % (N_POINTS / 4)) == 0) begin
          check_value("data_o impulse group", impulse_out, data_o);
        end
        if (frames_seen == 2) begin
          check_value("data_o against gapped frame", gapped_out[out_idx], data_o);
        end
        out_idx = out_idx + 1;
        if (out_idx == N_POINTS) begin
          out_idx     = 0;
          frames_seen = frames_seen + 1;
        end
      end else if (out_idx != 0) begin
        abort_run("data_valid_o dropped in the middle of an output frame");
      end
    end
  end

  initial begin : stimulus
    r4_stage_pkg::cplx_t frame [N_POINTS];
    r4_stage_pkg::cplx_t gapped_frame [N_POINTS];
    seed             = 46;
    rst              = 1'b0;
    sample_i         = '0;
    sample_valid_i   = 1'b0;
    impulse_out.re   = SAMPLE_W'(IMPULSE_AMP >>> SCALE_SHIFT);
    impulse_out.im   = '0;
    repeat (8) @(posedge clk);
    #2 rst = 1'b1;
    send_idle(4);

    fill_random(frame);  // group 0 becomes a unit impulse
    frame[0].re = SAMPLE_W'(IMPULSE_AMP);
    frame[0].im = '0;
    for (int m = 1; m < 4; m++) begin
      frame[m] = '0;
    end
    send_frame(frame, 1'b0);
    send_idle(10);

    fill_random(gapped_frame);
    send_frame(gapped_frame, 1'b1);
    send_frame(gapped_frame, 1'b0);  // same samples without gaps
    fill_random(frame);
    send_frame(frame, 1'b0);
    fill_random(frame);
    send_frame(frame, 1'b0);
    send_idle(1);

    wait (frames_seen == NUM_FRAMES);
    @(negedge clk);
    check_value("data_valid_o after last frame", 32'd0, {31'd0, data_valid_o});
    $display("TB PASSED");
    $finish;
  end

endmodule
